//--- Makefile
# Verilator flow for the instruction cache

VERILATOR ?= verilator
FILELIST  ?= icache.f
TB_TOP    ?= tb_icache
RTL_TOP   ?= icache_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= === PASS ===

RTL_SRCS ?= verilog/icache_cfg_pkg.sv \
            verilog/icache_bus_pkg.sv \
            verilog/cache_ram.sv \
            verilog/set_state.sv \
            verilog/icache_ctrl.sv \
            verilog/icache_top.sv

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)

# The run fails unless the pass message appears as a line of its own.
sim: build
	@out="$$(./$(BUILD_DIR)/$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- icache.f
verilog/icache_cfg_pkg.sv
verilog/icache_bus_pkg.sv
verilog/cache_ram.sv
verilog/set_state.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
testbench/tb_icache.sv

//--- testbench/icache_stimulus.txt
# opcode  byte-address  expected-instruction  refill-flag
# reset entries carry zeros in the last three columns
fetch 00001000 5a5a5e5a 1
fetch 00001000 5a5a5e5a 0
fetch 00001004 5a5a5e5b 0
fetch 00001000 5a5a5e5a 0
# set 5 with tags 010, 020, 030 and 040
fetch 00002028 5a5a5250 1
fetch 00004028 5a5a4a50 1
fetch 00002028 5a5a5250 0
fetch 00004028 5a5a4a50 0
fetch 0000202c 5a5a5251 0
fetch 0000402c 5a5a4a51 0
fetch 00002028 5a5a5250 0
fetch 00006028 5a5a4250 1
fetch 00002028 5a5a5250 0
fetch 00004028 5a5a4a50 1
fetch 00002028 5a5a5250 0
fetch 00006028 5a5a4250 1
# seven fetches in set 0 saturate both ages in set 5, so way 0 goes next
fetch 00001000 5a5a5e5a 0
fetch 00001004 5a5a5e5b 0
fetch 00001000 5a5a5e5a 0
fetch 00001004 5a5a5e5b 0
fetch 00001000 5a5a5e5a 0
fetch 00001004 5a5a5e5b 0
fetch 00001000 5a5a5e5a 0
fetch 00008028 5a5a7a50 1
fetch 00006028 5a5a4250 0
fetch 00002028 5a5a5250 1
reset 00000000 00000000 0
fetch 00002028 5a5a5250 1
fetch 00001000 5a5a5e5a 1
fetch 00001004 5a5a5e5b 0
fetch 00002028 5a5a5250 0
fetch 00abc010 5a70aa5e 1
fetch 00abc014 5a70aa5f 0
fetch fffffffc 65a5a5a5 1
fetch fffffff8 65a5a5a4 0
fetch 12345678 5ed74fc4 1
fetch 1234567c 5ed74fc5 0
fetch 00000000 5a5a5a5a 1
fetch 00001004 5a5a5e5b 0
fetch 00000004 5a5a5a5b 0

//--- testbench/tb_icache.sv
// Instruction cache testbench
`timescale 1ns/10ps

module tb_icache;

    localparam int          TIMEOUT_CYCLES = 100;
    localparam logic [31:0] WORD_PATTERN   = 32'h5a5a5a5a;

    logic                       clk;
    logic                       i_rst_n;
    logic                       i_fetch_req;
    logic [31:0]                i_fetch_addr;
    icache_bus_pkg::fetch_rsp_t o_fetch;
    logic                       o_busy;
    icache_bus_pkg::mem_req_t   o_mem;
    icache_bus_pkg::mem_rsp_t   i_mem;

    integer      seed;
    int          errors;
    int          prev_errors;
    int          tests;
    int          total_refills;
    bit          timed_out;
    int          fd;
    int          n;
    string       text_line;
    logic [39:0] op;
    logic [31:0] stim_addr;
    logic [31:0] stim_instr;
    logic [31:0] stim_refill;

    icache_top uut (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_fetch_req  (i_fetch_req),
        .i_fetch_addr (i_fetch_addr),
        .o_fetch      (o_fetch),
        .o_busy       (o_busy),
        .o_mem        (o_mem),
        .i_mem        (i_mem)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] word_at(input logic [31:0] word_addr);
        return word_addr ^ WORD_PATTERN;
    endfunction

    // Even word in the lower half of the line.
    function automatic icache_cfg_pkg::line_t line_at(input logic [31:0] line_addr);
        logic [31:0] even_addr;
        even_addr = {2'b00, line_addr[31:2]};
        return {word_at(even_addr + 32'd1), word_at(even_addr)};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        i_rst_n     = 1'b0;
        i_fetch_req = 1'b0;
        i_mem       = '0;
        for (int k = 0; k < 16; k++) begin
            @(negedge clk);
            if (k > 0) begin // The first edge has not yet taken the reset.
                check_value("o_busy", 32'(o_busy), 32'd0);
                check_value("o_mem.req", 32'(o_mem.req), 32'd0);
                check_value("o_fetch.valid", 32'(o_fetch.valid), 32'd0);
            end
        end
        @(posedge clk);
        #1;
        i_rst_n = 1'b1;
    endtask

    // Leaves a refill pending, so the cache is busy and requesting when reset comes.
    task automatic start_miss(input logic [31:0] addr);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        i_fetch_req  = 1'b1;
        i_fetch_addr = addr;
        @(posedge clk);
        #1;
        i_fetch_req = 1'b0;
        while (!o_mem.req && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!o_mem.req) begin
            $display("Timeout: no memory request within %0d cycles, fetch at %h",
                     TIMEOUT_CYCLES, addr);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_fetch(input logic [31:0] addr, input logic [31:0] exp_instr,
                             input logic [31:0] exp_refill);
        int cycles;
        int rsp_cycle;
        int lat_left;
        int refills;
        bit wait_rsp;
        bit done;
        cycles    = 0;
        rsp_cycle = 0;
        lat_left  = 0;
        refills   = 0;
        wait_rsp  = 1'b0;
        done      = 1'b0;
        @(posedge clk);
        #1;
        i_fetch_req  = 1'b1;
        i_fetch_addr = addr;
        @(posedge clk);
        #1;
        i_fetch_req = 1'b0; // The strobe was taken on this edge.
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            check_value("o_busy", 32'(o_busy), 32'd1);
            if (i_mem.valid) begin
                rsp_cycle = cycles;
                wait_rsp  = 1'b0;
                check_value("o_mem.req", 32'(o_mem.req), 32'd1);
            end else if (wait_rsp) begin
                if (!o_mem.req) begin
                    $display("Memory request dropped before its response, fetch at %h", addr);
                    errors++;
                end
            end else if (o_mem.req) begin
                wait_rsp = 1'b1;
                refills++;
                lat_left = 1 + int'($unsigned($random(seed)) % 8);
                check_value("o_mem.addr", o_mem.addr, {addr[31:3], 3'b000});
                check_value("miss request cycle", cycles, 32'd2);
            end
            if (o_fetch.valid) begin
                done = 1'b1;
                check_value("o_fetch.instr", o_fetch.instr, exp_instr);
                if (refills == 0) begin
                    check_value("hit latency", cycles, 32'd2);
                end else begin
                    check_value("refill latency", cycles - rsp_cycle, 32'd3);
                end
            end
            @(posedge clk);
            #1;
            i_mem.valid = 1'b0;
            if (wait_rsp) begin
                lat_left--;
                if (lat_left == 0) begin
                    i_mem.data  = line_at(o_mem.addr);
                    i_mem.valid = 1'b1;
                end
            end
        end
        if (!done) begin
            $display("Timeout: no instruction within %0d cycles, fetch at %h",
                     TIMEOUT_CYCLES, addr);
            errors++;
            timed_out = 1'b1;
        end
        check_value("refill count", refills, exp_refill);
        total_refills += refills;
    endtask

    initial begin
        clk           = 1'b0;
        i_rst_n       = 1'b0;
        i_fetch_req   = 1'b0;
        i_fetch_addr  = '0;
        i_mem         = '0;
        seed          = 32'h09fc1dd0;
        errors        = 0;
        tests         = 0;
        total_refills = 0;
        timed_out     = 1'b0;
        apply_reset();
        fd = $fopen("testbench/icache_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            errors++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                text_line = "";
                n = $fgets(text_line, fd);
                if (text_line.len() == 0 || text_line.getc(0) == "#") begin
                    continue;
                end
                n = $sscanf(text_line, "%s %h %h %d", op, stim_addr, stim_instr, stim_refill);
                if (n != 4) begin
                    continue;
                end
                tests++;
                prev_errors = errors;
                if (op == "fetch") begin
                    run_fetch(stim_addr, stim_instr, stim_refill);
                end else if (op == "reset") begin
                    start_miss(stim_addr);
                    apply_reset();
                end else begin
                    $display("Unknown opcode on stimulus entry %0d", tests);
                    errors++;
                end
                if (errors == prev_errors) begin
                    $display("test %0d: %s %h ok", tests, op, stim_addr);
                end else begin
                    $display("test %0d: %s %h FAILED", tests, op, stim_addr);
                end
            end
            $fclose(fd);
        end
        $display("%0d tests, %0d refills, %0d errors", tests, total_refills, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verilog/cache_ram.sv
// Set-indexed cache RAM
`timescale 1ns/10ps

module cache_ram #(
    parameter type entry_t = icache_cfg_pkg::line_t
) (
    input  logic                   clk,
    input  icache_cfg_pkg::index_t i_index,
    input  logic                   i_we,
    input  entry_t                 i_wdata,
    output entry_t                 o_rdata
);

    entry_t mem [icache_cfg_pkg::NUM_SETS];

    // A read in the cycle of a write returns the old entry.
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_index] <= i_wdata;
        end
        o_rdata <= mem[i_index];
    end

endmodule

//--- verilog/icache_bus_pkg.sv
// Instruction cache port bundles
package icache_bus_pkg;

    // Returned instruction; valid is a single-cycle pulse.
    typedef struct packed {
        logic [icache_cfg_pkg::WORD_W-1:0] instr;
        logic                              valid;
    } fetch_rsp_t;

    // Line fill request; req is held until the response pulse.
    typedef struct packed {
        logic                              req;
        logic [icache_cfg_pkg::ADDR_W-1:0] addr;  // Line aligned, low three bits zero.
    } mem_req_t;

    // Line fill response.
    typedef struct packed {
        icache_cfg_pkg::line_t data;  // Even word in the lower half.
        logic                  valid;
    } mem_rsp_t;

endpackage

//--- verilog/icache_cfg_pkg.sv
// Instruction cache geometry
package icache_cfg_pkg;

    // Fetch address and instruction widths.
    localparam int ADDR_W  = 32;
    localparam int WORD_W  = 32;

    // Two instructions per line.
    localparam int LINE_W  = 2 * WORD_W;

    // Address split, from the top bit down.
    localparam int TAG_W   = 23;
    localparam int INDEX_W = 6;

    localparam int NUM_SETS = 1 << INDEX_W;

    // Replacement age counters, one per way and set.
    localparam int AGE_W = 3;
    localparam logic [AGE_W-1:0] AGE_MAX = AGE_W'(7); // Saturation value.

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [LINE_W-1:0]  line_t;

    // Byte address as seen by the cache.
    typedef struct packed {
        tag_t       tag;
        index_t     index;
        logic       word_sel;  // Picks the upper word of the line when set.
        logic [1:0] byte_sel;  // Instructions are word aligned.
    } addr_fields_t;

endpackage

//--- verilog/icache_ctrl.sv
// Instruction cache controller
`timescale 1ns/10ps

module icache_ctrl (
    input  logic                              clk,
    input  logic                              i_rst_n,

    input  logic                              i_fetch_req,
    input  logic [icache_cfg_pkg::ADDR_W-1:0] i_fetch_addr,
    output icache_bus_pkg::fetch_rsp_t        o_fetch,
    output logic                              o_busy,

    output icache_bus_pkg::mem_req_t          o_mem,
    input  icache_bus_pkg::mem_rsp_t          i_mem,

    output icache_cfg_pkg::index_t            o_index,
    output icache_cfg_pkg::tag_t              o_tag_wdata,
    output icache_cfg_pkg::line_t             o_line_wdata,
    output logic [1:0]                        o_we,
    input  icache_cfg_pkg::tag_t              i_tag0,
    input  icache_cfg_pkg::tag_t              i_tag1,
    input  icache_cfg_pkg::line_t             i_line0,
    input  icache_cfg_pkg::line_t             i_line1,

    output logic                              o_access,
    output logic                              o_touch,
    output logic                              o_touch_way,
    output logic                              o_fill,
    input  logic [1:0]                        i_valid,
    input  logic                              i_victim
);

    typedef enum logic [4:0] {
        S_IDLE    = 5'b00001,
        S_LOOKUP  = 5'b00010,
        S_COMPARE = 5'b00100,
        S_MISS    = 5'b01000,
        S_REFILL  = 5'b10000
    } state_t;

    state_t                       state;
    state_t                       state_nxt;
    icache_cfg_pkg::addr_fields_t addr_q;
    logic                         accept;
    logic                         hit0;
    logic                         hit1;
    logic                         hit;
    icache_cfg_pkg::line_t        hit_line;

    assign accept = (state == S_IDLE) && i_fetch_req; // Strobes while busy are dropped.

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= i_fetch_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (accept) begin
                    state_nxt = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                state_nxt = S_COMPARE; // RAM read is in flight.
            end
            S_COMPARE: begin
                if (hit) begin
                    state_nxt = S_IDLE;
                end else begin
                    state_nxt = S_MISS;
                end
            end
            S_MISS: begin
                if (i_mem.valid) begin
                    state_nxt = S_REFILL;
                end
            end
            S_REFILL: begin
                state_nxt = S_LOOKUP; // The read beside the write saw stale data.
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    // Tags and valid bits both belong to the latched index.
    assign hit0 = i_valid[0] && (i_tag0 == addr_q.tag);
    assign hit1 = i_valid[1] && (i_tag1 == addr_q.tag);
    assign hit  = hit0 || hit1;

    assign hit_line = hit0 ? i_line0 : i_line1;

    always_comb begin
        o_fetch.valid = (state == S_COMPARE) && hit;
        if (addr_q.word_sel) begin
            o_fetch.instr = hit_line[icache_cfg_pkg::LINE_W-1:icache_cfg_pkg::WORD_W];
        end else begin
            o_fetch.instr = hit_line[icache_cfg_pkg::WORD_W-1:0];
        end
    end

    assign o_busy = (state != S_IDLE);

    // Request rises with the miss decision and holds through the response.
    assign o_mem.req  = ((state == S_COMPARE) && !hit) || (state == S_MISS);
    assign o_mem.addr = {addr_q.tag, addr_q.index, 3'b000};

    assign o_index      = addr_q.index;
    assign o_tag_wdata  = addr_q.tag;
    assign o_line_wdata = i_mem.data;

    assign o_fill = (state == S_MISS) && i_mem.valid;
    assign o_we   = {o_fill && i_victim, o_fill && !i_victim};

    assign o_access    = accept;
    assign o_touch     = o_fetch.valid || o_fill;
    assign o_touch_way = o_fill ? i_victim : hit1 && !hit0;

endmodule

//--- verilog/icache_top.sv
// Two-way instruction cache
`timescale 1ns/10ps

module icache_top (
    input  logic                              clk,
    input  logic                              i_rst_n,
    input  logic                              i_fetch_req,
    input  logic [icache_cfg_pkg::ADDR_W-1:0] i_fetch_addr,
    output icache_bus_pkg::fetch_rsp_t        o_fetch,
    output logic                              o_busy,
    output icache_bus_pkg::mem_req_t          o_mem,
    input  icache_bus_pkg::mem_rsp_t          i_mem
);

    icache_cfg_pkg::index_t index;
    icache_cfg_pkg::tag_t   tag_wdata;
    icache_cfg_pkg::line_t  line_wdata;
    logic [1:0]             we;
    icache_cfg_pkg::tag_t   tag0;
    icache_cfg_pkg::tag_t   tag1;
    icache_cfg_pkg::line_t  line0;
    icache_cfg_pkg::line_t  line1;
    logic                   access;
    logic                   touch;
    logic                   touch_way;
    logic                   fill;
    logic [1:0]             valid;
    logic                   victim;

    icache_ctrl u_ctrl (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_fetch_req  (i_fetch_req),
        .i_fetch_addr (i_fetch_addr),
        .o_fetch      (o_fetch),
        .o_busy       (o_busy),
        .o_mem        (o_mem),
        .i_mem        (i_mem),
        .o_index      (index),
        .o_tag_wdata  (tag_wdata),
        .o_line_wdata (line_wdata),
        .o_we         (we),
        .i_tag0       (tag0),
        .i_tag1       (tag1),
        .i_line0      (line0),
        .i_line1      (line1),
        .o_access     (access),
        .o_touch      (touch),
        .o_touch_way  (touch_way),
        .o_fill       (fill),
        .i_valid      (valid),
        .i_victim     (victim)
    );

    set_state u_set_state (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_index     (index),
        .i_access    (access),
        .i_touch     (touch),
        .i_touch_way (touch_way),
        .i_fill      (fill),
        .o_valid     (valid),
        .o_victim    (victim)
    );

    cache_ram #(.entry_t(icache_cfg_pkg::tag_t)) u_tag0 (
        .clk     (clk),
        .i_index (index),
        .i_we    (we[0]),
        .i_wdata (tag_wdata),
        .o_rdata (tag0)
    );

    cache_ram #(.entry_t(icache_cfg_pkg::tag_t)) u_tag1 (
        .clk     (clk),
        .i_index (index),
        .i_we    (we[1]),
        .i_wdata (tag_wdata),
        .o_rdata (tag1)
    );

    cache_ram #(.entry_t(icache_cfg_pkg::line_t)) u_line0 (
        .clk     (clk),
        .i_index (index),
        .i_we    (we[0]),
        .i_wdata (line_wdata),
        .o_rdata (line0)
    );

    cache_ram #(.entry_t(icache_cfg_pkg::line_t)) u_line1 (
        .clk     (clk),
        .i_index (index),
        .i_we    (we[1]),
        .i_wdata (line_wdata),
        .o_rdata (line1)
    );

endmodule

//--- verilog/set_state.sv
// Valid bits and replacement ages
`timescale 1ns/10ps

module set_state (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  icache_cfg_pkg::index_t i_index,
    input  logic                   i_access,
    input  logic                   i_touch,
    input  logic                   i_touch_way,
    input  logic                   i_fill,
    output logic [1:0]             o_valid,
    output logic                   o_victim
);

    logic [1:0]                       valid_q [icache_cfg_pkg::NUM_SETS];
    logic [icache_cfg_pkg::AGE_W-1:0] age_q   [icache_cfg_pkg::NUM_SETS][2];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int s = 0; s < icache_cfg_pkg::NUM_SETS; s++) begin
                valid_q[s]  <= '0;
                age_q[s][0] <= '0;
                age_q[s][1] <= '0;
            end
        end else begin
            // Every fetch ages every line in the cache.
            if (i_access) begin
                for (int s = 0; s < icache_cfg_pkg::NUM_SETS; s++) begin
                    for (int w = 0; w < 2; w++) begin
                        if (age_q[s][w] != icache_cfg_pkg::AGE_MAX) begin
                            age_q[s][w] <= age_q[s][w] + 1'b1;
                        end
                    end
                end
            end
            if (i_touch) begin
                age_q[i_index][i_touch_way] <= '0; // Most recently used.
            end
            if (i_fill) begin
                valid_q[i_index][i_touch_way] <= 1'b1;
            end
        end
    end

    assign o_valid = valid_q[i_index];

    // An empty way wins, then the older way, then way 0.
    always_comb begin
        if (!o_valid[0]) begin
            o_victim = 1'b0;
        end else if (!o_valid[1]) begin
            o_victim = 1'b1;
        end else begin
            o_victim = age_q[i_index][1] > age_q[i_index][0];
        end
    end

endmodule
